/* sim.f */
logic/fetchPkg.sv
logic/preDecode.sv
logic/branchFilter.sv
logic/ctiPointers.sv
logic/ctiQueue.sv
logic/fetchStage2.sv
tests/fetchStage2_chk.sv
tests/fetchStage2Tb.sv

/* Makefile */
# Verilator simulation of fetch stage 2.

OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
	  --top-module fetchStage2Tb -f sim.f --Mdir $(OBJ_DIR) -o simv
	./$(OBJ_DIR)/simv | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/fetchStage2Tb.sv */
/* Testbench for fetch stage 2: clock and reset, random bundles,
   reference predecode and filter, queue model and compare tasks. */

`timescale 1ns/1ps

module fetchStage2Tb import fetchPkg::*; ();

  localparam int CtiDepth   = 16;
  localparam int NumBundles = 400;
  localparam int CycleLimit = NumBundles * 20 + 200;

  typedef struct packed {
    logic               isCtrl;
    ctrlType_e          ctrlType;
    logic [PcWidth-1:0] target;
  } slotRef_t;

  typedef struct packed {
    logic [FetchWidth-1:0] valid;
    logic                  found;
    logic [1:0]            slot;
  } filterRef_t;

  logic                          clk = 1'b0;
  logic                          rst_i;
  logic                          fs1Ready_i;
  logic [PcWidth-1:0]            pc_i;
  logic [FetchWidth*InstWidth-1:0] bundle_i;
  logic [FetchWidth-1:0]         predTaken_i;
  logic [FetchWidth-1:0]         btbHit_i;
  logic [PcWidth-1:0]            btbTarget_i [FetchWidth];
  logic [PcWidth-1:0]            rasTarget_i;
  logic                          stall_i;
  ctiResolve_t                   resolve_i;
  logic                          commit_i;
  instPacket_t                   instPacket_o [FetchWidth];
  logic [FetchWidth-1:0]         instValid_o;
  logic                          redirect_o;
  logic [PcWidth-1:0]            redirectTarget_o;
  logic                          redirectCall_o;
  logic                          redirectReturn_o;
  logic [PcWidth-1:0]            callPc_o;
  ctiUpdate_t                    update_o;
  logic                          updateEn_o;
  logic                          ctiFull_o;
  logic                          fs2Ready_o;

  // Queue model, advanced at each falling edge for the next rising edge.
  ctiUpdate_t modelEntries [CtiDepth];
  int         modelHead = 0;
  int         modelTail = 0;
  int         modelCount = 0;
  logic       expUpdateEn = 1'b0;
  ctiUpdate_t expUpdate;
  logic       checkOn = 1'b0;
  int         cycles = 0;

  always #2 clk = ~clk;

  fetchStage2 #(
    .CtiDepth(CtiDepth)
  ) i_dut (
    .clk(clk), .rst_i(rst_i), .fs1Ready_i(fs1Ready_i), .pc_i(pc_i),
    .bundle_i(bundle_i), .predTaken_i(predTaken_i), .btbHit_i(btbHit_i),
    .btbTarget_i(btbTarget_i), .rasTarget_i(rasTarget_i), .stall_i(stall_i),
    .instPacket_o(instPacket_o), .instValid_o(instValid_o), .redirect_o(redirect_o),
    .redirectTarget_o(redirectTarget_o), .redirectCall_o(redirectCall_o),
    .redirectReturn_o(redirectReturn_o), .callPc_o(callPc_o), .resolve_i(resolve_i),
    .commit_i(commit_i), .update_o(update_o), .updateEn_o(updateEn_o),
    .ctiFull_o(ctiFull_o), .fs2Ready_o(fs2Ready_o)
  );

  bind ctiQueue fetchStage2_chk #(.CtiDepth(CtiDepth)) i_chk (
    .clk(clk), .rst_i(rst_i), .commit_i(commit_i), .empty_i(empty),
    .updateEn_i(updateEn_o), .full_i(full_o), .squash_i(squash),
    .head_i(head), .tail_i(tail), .count_i(i_ptrs.count)
  );

  function automatic slotRef_t predecodeRef(input logic [PcWidth-1:0] pc,
      input logic [InstWidth-1:0] inst, input logic predTaken,
      input logic [PcWidth-1:0] btbTarget, input logic [PcWidth-1:0] rasTarget);
    slotRef_t           r;
    logic [PcWidth-1:0] offset;
    offset = {{14{inst[15]}}, inst[15:0], 2'b00};
    r = '{isCtrl: 1'b1, ctrlType: CtReturn, target: btbTarget};
    case (inst[31:26])
      OpBranch: begin
        r.ctrlType = CtBranch;
        r.target   = predTaken ? pc + 32'd4 + offset : pc + 32'd4;  // Predicted next pc.
      end
      OpJump, OpCall: begin
        r.ctrlType = (inst[31:26] == OpJump) ? CtJump : CtCall;
        r.target   = {pc[31:28], inst[25:0], 2'b00};
      end
      OpReturn: r.target = rasTarget;
      default:  r.isCtrl = 1'b0;
    endcase
    return r;
  endfunction

  function automatic filterRef_t filterRef(input slotRef_t s [FetchWidth],
      input logic [FetchWidth-1:0] predTaken);
    filterRef_t f;
    f = '{valid: '1, found: 1'b0, slot: 2'd0};
    for (int k = FetchWidth - 1; k >= 0; k--) begin
      if (s[k].isCtrl && (s[k].ctrlType != CtBranch || predTaken[k])) begin
        f.found = 1'b1;
        f.slot  = 2'(k);
      end
    end
    for (int k = 0; k < FetchWidth; k++) begin
      f.valid[k] = !f.found || k <= int'(f.slot);
    end
    return f;
  endfunction

  function automatic logic [InstWidth-1:0] randomInst();
    logic [5:0] op;
    case ($urandom % 5)
      0:       op = OpBranch;
      1:       op = OpJump;
      2:       op = OpCall;
      3:       op = OpReturn;
      default: op = 6'h10 + 6'($urandom % 32);  // Never a control opcode.
    endcase
    return {op, 26'($urandom)};
  endfunction

  task automatic reportMismatch(input string name, input string expStr, input string actStr);
    $display("FAIL t=%0t %s expected %s actual %s", $time, name, expStr, actStr);
    $display("TEST FAIL");
    $fatal(1, "Stopped at the first mismatch.");
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    if (act !== exp) reportMismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic checkWord(input string name, input logic [PcWidth-1:0] exp,
      input logic [PcWidth-1:0] act);
    if (act !== exp) reportMismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic checkPacket(input string name, input instPacket_t exp, input instPacket_t act);
    if (act !== exp) reportMismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic checkUpdate(input string name, input ctiUpdate_t exp, input ctiUpdate_t act);
    if (act !== exp) reportMismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic setIdle();
    fs1Ready_i  = 1'b0;
    stall_i     = 1'b0;
    pc_i        = '0;
    bundle_i    = '0;
    predTaken_i = '0;
    btbHit_i    = '0;
    rasTarget_i = '0;
    resolve_i   = '0;
    commit_i    = 1'b0;
    for (int k = 0; k < FetchWidth; k++) begin
      btbTarget_i[k] = '0;
    end
  endtask

  // Mixed cycles add commits and resolves to the bundle traffic.
  task automatic driveCycle(input logic mixed);
    fs1Ready_i  = ($urandom % 10) != 0;
    stall_i     = ($urandom % 7) == 0;
    pc_i        = $urandom & 32'hffff_fffc;
    predTaken_i = 4'($urandom);
    btbHit_i    = 4'($urandom);
    rasTarget_i = $urandom & 32'hffff_fffc;
    for (int k = 0; k < FetchWidth; k++) begin
      bundle_i[k*InstWidth +: InstWidth] = randomInst();
      btbTarget_i[k] = $urandom;
    end
    commit_i  = mixed && ($urandom % 3) == 0;
    resolve_i = '0;
    if (mixed && modelCount != 0 && ($urandom % 4) == 0) begin
      resolve_i.valid      = 1'b1;
      resolve_i.tag        = ctiTag_t'((modelHead + int'($urandom % modelCount)) % CtiDepth);
      resolve_i.target     = $urandom;
      resolve_i.taken      = 1'($urandom);
      resolve_i.mispredict = ($urandom % 4) == 0;
      if (resolve_i.mispredict) fs1Ready_i = 1'b0;  // No bundle in a squash cycle.
    end
  endtask

  always @(negedge clk) begin
    slotRef_t    s [FetchWidth];
    filterRef_t  f;
    instPacket_t expPkt;
    ctiUpdate_t  popped;
    logic        full;
    logic        accept;
    logic        pop;
    logic        miss;
    int          pushed;
    int          slotTag;
    if (checkOn) begin
      full   = modelCount > CtiDepth - FetchWidth;
      accept = fs1Ready_i && !stall_i && !full;
      pop    = commit_i && modelCount != 0;
      popped = modelEntries[modelHead];
      for (int k = 0; k < FetchWidth; k++) begin
        s[k] = predecodeRef(pc_i + PcWidth'(4 * k), bundle_i[k*InstWidth +: InstWidth],
                            predTaken_i[k], btbTarget_i[k], rasTarget_i);
      end
      f = filterRef(s, predTaken_i);
      checkBit("ctiFull_o", full, ctiFull_o);
      checkBit("fs2Ready_o", fs1Ready_i && !full, fs2Ready_o);
      pushed = 0;
      for (int k = 0; k < FetchWidth; k++) begin
        slotTag = (modelTail + pushed) % CtiDepth;
        expPkt  = '{inst: bundle_i[k*InstWidth +: InstWidth], pc: pc_i + PcWidth'(4 * k),
                    target: s[k].target, tag: ctiTag_t'(slotTag), predTaken: predTaken_i[k]};
        checkPacket($sformatf("instPacket_o[%0d]", k), expPkt, instPacket_o[k]);
        checkBit($sformatf("instValid_o[%0d]", k), f.valid[k], instValid_o[k]);
        if (f.valid[k] && s[k].isCtrl) begin
          if (accept) begin
            modelEntries[slotTag] = '{pc: pc_i + PcWidth'(4 * k), target: s[k].target,
                                      ctrlType: s[k].ctrlType,
                                      taken: predTaken_i[k] || s[k].ctrlType != CtBranch};
          end
          pushed++;
        end
      end
      miss = f.found && !btbHit_i[f.slot];
      checkBit("redirect_o", miss && !stall_i && !full, redirect_o);
      checkBit("redirectCall_o", miss && s[f.slot].ctrlType == CtCall, redirectCall_o);
      checkBit("redirectReturn_o", miss && s[f.slot].ctrlType == CtReturn, redirectReturn_o);
      if (f.found) begin
        checkWord("redirectTarget_o", s[f.slot].target, redirectTarget_o);
        checkWord("callPc_o", pc_i + PcWidth'(4 * int'(f.slot)), callPc_o);
      end
      checkBit("updateEn_o", expUpdateEn, updateEn_o);
      if (expUpdateEn) checkUpdate("update_o", expUpdate, update_o);
      expUpdateEn = pop;
      if (pop) expUpdate = popped;
      if (resolve_i.valid) begin
        modelEntries[int'(resolve_i.tag) % CtiDepth].target = resolve_i.target;
        modelEntries[int'(resolve_i.tag) % CtiDepth].taken  = resolve_i.taken;
      end
      if (resolve_i.valid && resolve_i.mispredict) begin
        modelCount = (int'(resolve_i.tag) - modelHead + CtiDepth) % CtiDepth + 1 - int'(pop);
        modelTail  = (int'(resolve_i.tag) + 1) % CtiDepth;  // Younger entries squashed.
      end else if (accept) begin
        modelTail  = (modelTail + pushed) % CtiDepth;
        modelCount = modelCount + pushed - int'(pop);
      end else begin
        modelCount = modelCount - int'(pop);
      end
      if (pop) modelHead = (modelHead + 1) % CtiDepth;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > CycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles.", CycleLimit);
      $display("TEST FAIL");
      $fatal(1, "Simulation timed out.");
    end
  end

  initial begin
    void'($urandom(32'h4746_a66c));
    rst_i = 1'b1;
    setIdle();
    repeat (8) @(posedge clk);
    #1 rst_i = 1'b0;
    checkOn = 1'b1;
    // First 40 bundles fill the queue with no commits.
    for (int n = 0; n < NumBundles; n++) begin
      @(posedge clk);
      #1 driveCycle(n >= 40);
    end
    @(posedge clk);
    #1 setIdle();
    commit_i = 1'b1;
    while (modelCount != 0) @(posedge clk);
    #1 commit_i = 1'b0;
    repeat (3) @(posedge clk);
    $display("TEST PASS");
    $finish;
  end

endmodule

/* tests/fetchStage2_chk.sv */
/* Bound checker for the control-transfer queue: occupancy bound,
   commit to update timing, and no push while full. */

`timescale 1ns/1ps

module fetchStage2_chk #(
  parameter int CtiDepth = 16
) (
  input logic                        clk,
  input logic                        rst_i,
  input logic                        commit_i,
  input logic                        empty_i,
  input logic                        updateEn_i,
  input logic                        full_i,
  input logic                        squash_i,
  input logic [$clog2(CtiDepth)-1:0] head_i,
  input logic [$clog2(CtiDepth)-1:0] tail_i,
  input logic [$clog2(CtiDepth):0]   count_i
);

  countBound: assert property (@(posedge clk) disable iff (rst_i)
    int'(count_i) <= CtiDepth)
    else $error("Queue occupancy %0d is above depth %0d.", count_i, CtiDepth);

  // Update strobe and head move together, one cycle after an honored commit.
  updateAfterCommit: assert property (@(posedge clk) disable iff (rst_i)
    (commit_i && !empty_i) |=> (updateEn_i && head_i == $past(head_i) + 1'b1))
    else $error("Update strobe or head advance missing after a commit.");

  noUpdateWithoutCommit: assert property (@(posedge clk) disable iff (rst_i)
    !(commit_i && !empty_i) |=> (!updateEn_i && head_i == $past(head_i)))
    else $error("Update strobe or head move without a commit.");

  noPushWhileFull: assert property (@(posedge clk) disable iff (rst_i)
    (full_i && !squash_i) |=> tail_i == $past(tail_i))
    else $error("Tail moved while the queue is full.");

endmodule

/* logic/fetchStage2.sv */
/* Fetch stage 2 top: slot split, four predecoders, the bundle
   filter, the control-transfer queue and packet assembly. */

`timescale 1ns/1ps

module fetchStage2 import fetchPkg::*; #(
  parameter int CtiDepth = 16
) (
  input  logic                          clk,
  input  logic                          rst_i,
  input  logic                          fs1Ready_i,
  input  logic [PcWidth-1:0]            pc_i,
  input  logic [FetchWidth*InstWidth-1:0] bundle_i,
  input  logic [FetchWidth-1:0]         predTaken_i,
  input  logic [FetchWidth-1:0]         btbHit_i,
  input  logic [PcWidth-1:0]            btbTarget_i [FetchWidth],
  input  logic [PcWidth-1:0]            rasTarget_i,
  input  logic                          stall_i,
  output instPacket_t                   instPacket_o [FetchWidth],
  output logic [FetchWidth-1:0]         instValid_o,
  output logic                          redirect_o,
  output logic [PcWidth-1:0]            redirectTarget_o,
  output logic                          redirectCall_o,
  output logic                          redirectReturn_o,
  output logic [PcWidth-1:0]            callPc_o,
  input  ctiResolve_t                   resolve_i,
  input  logic                          commit_i,
  output ctiUpdate_t                    update_o,
  output logic                          updateEn_o,
  output logic                          ctiFull_o,
  output logic                          fs2Ready_o
);

  logic [PcWidth-1:0]    slotPc [FetchWidth];
  instWord_u             slotInst [FetchWidth];
  logic [FetchWidth-1:0] isCtrl;
  ctrlType_e             ctrlType [FetchWidth];
  logic [PcWidth-1:0]    target [FetchWidth];
  logic [FetchWidth-1:0] push;
  ctiTag_t               tag [FetchWidth];
  logic                  full;

  for (genvar k = 0; k < FetchWidth; k++) begin : genSlot
    assign slotPc[k]   = pc_i + PcWidth'(4 * k);  // Slot 0 in the low word.
    assign slotInst[k] = bundle_i[k*InstWidth +: InstWidth];

    preDecode i_preDecode (
      .pc_i       (slotPc[k]),
      .inst_i     (slotInst[k]),
      .predTaken_i(predTaken_i[k]),
      .btbTarget_i(btbTarget_i[k]),
      .rasTarget_i(rasTarget_i),
      .isCtrl_o   (isCtrl[k]),
      .ctrlType_o (ctrlType[k]),
      .target_o   (target[k])
    );

    assign instPacket_o[k] = '{inst:      slotInst[k],
                               pc:        slotPc[k],
                               target:    target[k],
                               tag:       tag[k],
                               predTaken: predTaken_i[k]};
  end

  branchFilter i_filter (
    .isCtrl_i        (isCtrl),
    .ctrlType_i      (ctrlType),
    .target_i        (target),
    .predTaken_i     (predTaken_i),
    .btbHit_i        (btbHit_i),
    .pc_i            (slotPc),
    .stall_i         (stall_i),
    .full_i          (full),
    .valid_o         (instValid_o),
    .push_o          (push),
    .redirect_o      (redirect_o),
    .redirectTarget_o(redirectTarget_o),
    .redirectCall_o  (redirectCall_o),
    .redirectReturn_o(redirectReturn_o),
    .callPc_o        (callPc_o)
  );

  ctiQueue #(
    .CtiDepth(CtiDepth)
  ) i_queue (
    .clk        (clk),
    .rst_i      (rst_i),
    .fs1Ready_i (fs1Ready_i),
    .stall_i    (stall_i),
    .push_i     (push),
    .pc_i       (slotPc),
    .ctrlType_i (ctrlType),
    .target_i   (target),
    .predTaken_i(predTaken_i),
    .resolve_i  (resolve_i),
    .commit_i   (commit_i),
    .tag_o      (tag),
    .update_o   (update_o),
    .updateEn_o (updateEn_o),
    .full_o     (full)
  );

  assign ctiFull_o  = full;
  assign fs2Ready_o = fs1Ready_i & ~full;  // Decode stall is not folded in.

endmodule

/* logic/ctiQueue.sv */
/* Control-transfer queue: tag assignment per bundle, entry storage,
   resolve writes from execute and the registered commit update. */

`timescale 1ns/1ps

module ctiQueue import fetchPkg::*; #(
  parameter int CtiDepth = 16
) (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  fs1Ready_i,
  input  logic                  stall_i,
  input  logic [FetchWidth-1:0] push_i,
  input  logic [PcWidth-1:0]    pc_i [FetchWidth],
  input  ctrlType_e             ctrlType_i [FetchWidth],
  input  logic [PcWidth-1:0]    target_i [FetchWidth],
  input  logic [FetchWidth-1:0] predTaken_i,
  input  ctiResolve_t           resolve_i,
  input  logic                  commit_i,
  output ctiTag_t               tag_o [FetchWidth],
  output ctiUpdate_t            update_o,
  output logic                  updateEn_o,
  output logic                  full_o
);

  localparam int TagWidth = $clog2(CtiDepth);

  ctiUpdate_t          entries [CtiDepth];
  logic [TagWidth-1:0] head;
  logic [TagWidth-1:0] tail;
  logic [TagWidth-1:0] resolveTag;
  logic [TagWidth-1:0] slotTag [FetchWidth];
  logic [2:0]          pushTotal;
  logic [2:0]          pushCount;
  logic                accept;
  logic                empty;
  logic                pop;
  logic                squash;

  assign accept     = fs1Ready_i & ~stall_i & ~full_o;
  assign pop        = commit_i & ~empty;
  assign squash     = resolve_i.valid & resolve_i.mispredict;
  assign resolveTag = resolve_i.tag[TagWidth-1:0];

  // Tag is the tail plus the earlier pushed slots of this bundle.
  always_comb begin
    pushTotal = '0;
    for (int k = 0; k < FetchWidth; k++) begin
      slotTag[k] = tail + TagWidth'(pushTotal);
      tag_o[k]   = ctiTag_t'(slotTag[k]);
      pushTotal  = pushTotal + 3'(push_i[k]);
    end
  end

  assign pushCount = accept ? pushTotal : 3'd0;

  ctiPointers #(
    .CtiDepth(CtiDepth)
  ) i_ptrs (
    .clk        (clk),
    .rst_i      (rst_i),
    .pushCount_i(pushCount),
    .pop_i      (pop),
    .squash_i   (squash),
    .squashTag_i(resolveTag),
    .head_o     (head),
    .tail_o     (tail),
    .full_o     (full_o),
    .empty_o    (empty)
  );

  always_ff @(posedge clk) begin
    for (int k = 0; k < FetchWidth; k++) begin
      if (accept && push_i[k]) begin
        entries[slotTag[k]] <= '{pc:       pc_i[k],
                                 target:   target_i[k],
                                 ctrlType: ctrlType_i[k],
                                 taken:    predTaken_i[k] | (ctrlType_i[k] != CtBranch)};
      end
    end
    if (resolve_i.valid) begin
      entries[resolveTag].target <= resolve_i.target;  // Execute outcome wins.
      entries[resolveTag].taken  <= resolve_i.taken;
    end
    if (pop) update_o <= entries[head];
  end

  always_ff @(posedge clk) begin
    if (rst_i) updateEn_o <= 1'b0;
    else       updateEn_o <= pop;
  end

endmodule

/* logic/ctiPointers.sv */
/* Head, tail and occupancy counters of the control-transfer
   queue, with tail reload on a squash. */

`timescale 1ns/1ps

module ctiPointers import fetchPkg::*; #(
  parameter int CtiDepth = 16
) (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic [2:0]                  pushCount_i,
  input  logic                        pop_i,
  input  logic                        squash_i,
  input  logic [$clog2(CtiDepth)-1:0] squashTag_i,
  output logic [$clog2(CtiDepth)-1:0] head_o,
  output logic [$clog2(CtiDepth)-1:0] tail_o,
  output logic                        full_o,
  output logic                        empty_o
);

  localparam int TagWidth   = $clog2(CtiDepth);
  localparam int CountWidth = TagWidth + 1;

  logic [CountWidth-1:0] count;
  logic [TagWidth-1:0]   squashSpan;

  assign squashSpan = squashTag_i - head_o;  // Entries older than the squashed tag.

  always_ff @(posedge clk) begin
    if (rst_i) begin
      head_o <= '0;
      tail_o <= '0;
      count  <= '0;
    end else begin
      if (pop_i) head_o <= head_o + 1'b1;
      if (squash_i) begin
        tail_o <= squashTag_i + 1'b1;  // Keep the mispredicted entry.
        count  <= {1'b0, squashSpan} + CountWidth'(1) - CountWidth'(pop_i);
      end else begin
        tail_o <= tail_o + TagWidth'(pushCount_i);
        count  <= count + CountWidth'(pushCount_i) - CountWidth'(pop_i);
      end
    end
  end

  // Room for a whole bundle is kept in reserve.
  assign full_o  = count > CountWidth'(CtiDepth - FetchWidth);
  assign empty_o = count == '0;

endmodule

/* logic/branchFilter.sv */
/* Bundle filter: first taken control slot, slot valid and queue
   push vectors, BTB check and the early redirect to decode. */

`timescale 1ns/1ps

module branchFilter import fetchPkg::*; (
  input  logic [FetchWidth-1:0] isCtrl_i,
  input  ctrlType_e             ctrlType_i [FetchWidth],
  input  logic [PcWidth-1:0]    target_i [FetchWidth],
  input  logic [FetchWidth-1:0] predTaken_i,
  input  logic [FetchWidth-1:0] btbHit_i,
  input  logic [PcWidth-1:0]    pc_i [FetchWidth],
  input  logic                  stall_i,
  input  logic                  full_i,
  output logic [FetchWidth-1:0] valid_o,
  output logic [FetchWidth-1:0] push_o,
  output logic                  redirect_o,
  output logic [PcWidth-1:0]    redirectTarget_o,
  output logic                  redirectCall_o,
  output logic                  redirectReturn_o,
  output logic [PcWidth-1:0]    callPc_o
);

  logic [FetchWidth-1:0] taken;
  logic                  found;
  logic                  btbMiss;

  always_comb begin
    for (int k = 0; k < FetchWidth; k++) begin
      taken[k] = isCtrl_i[k] & ((ctrlType_i[k] != CtBranch) | predTaken_i[k]);
    end
  end

  // Slots after the first taken one are dropped.
  always_comb begin
    found            = 1'b0;
    btbMiss          = 1'b0;
    valid_o          = '1;
    redirectTarget_o = '0;
    callPc_o         = '0;
    redirectCall_o   = 1'b0;
    redirectReturn_o = 1'b0;
    for (int k = 0; k < FetchWidth; k++) begin
      if (found) begin
        valid_o[k] = 1'b0;
      end else if (taken[k]) begin
        found            = 1'b1;
        btbMiss          = ~btbHit_i[k];
        redirectTarget_o = target_i[k];
        callPc_o         = pc_i[k];
        redirectCall_o   = ~btbHit_i[k] & (ctrlType_i[k] == CtCall);
        redirectReturn_o = ~btbHit_i[k] & (ctrlType_i[k] == CtReturn);
      end
    end
  end

  assign push_o     = valid_o & isCtrl_i;  // Every kept control slot gets a tag.
  assign redirect_o = btbMiss & ~stall_i & ~full_i;

endmodule

/* logic/preDecode.sv */
/* Single-slot predecoder: control type and predicted target
   of one instruction. */

`timescale 1ns/1ps

module preDecode import fetchPkg::*; (
  input  logic [PcWidth-1:0] pc_i,
  input  instWord_u          inst_i,
  input  logic               predTaken_i,
  input  logic [PcWidth-1:0] btbTarget_i,
  input  logic [PcWidth-1:0] rasTarget_i,
  output logic               isCtrl_o,
  output ctrlType_e          ctrlType_o,
  output logic [PcWidth-1:0] target_o
);

  logic [PcWidth-1:0] fallThrough;
  logic [PcWidth-1:0] branchTarget;
  logic [PcWidth-1:0] jumpTarget;

  assign fallThrough  = pc_i + PcWidth'(4);
  assign branchTarget = fallThrough + PcWidth'($signed({inst_i.br.offset, 2'b00}));
  assign jumpTarget   = {pc_i[PcWidth-1 -: 4], inst_i.jmp.index, 2'b00};

  // The slot target is the predicted next pc, so a branch predicted
  // not taken carries its fall-through address.
  always_comb begin
    isCtrl_o   = 1'b1;
    ctrlType_o = CtReturn;
    target_o   = btbTarget_i;
    case (inst_i.jmp.opcode)
      OpBranch: begin
        ctrlType_o = CtBranch;
        target_o   = predTaken_i ? branchTarget : fallThrough;
      end
      OpJump: begin
        ctrlType_o = CtJump;
        target_o   = jumpTarget;
      end
      OpCall: begin
        ctrlType_o = CtCall;
        target_o   = jumpTarget;
      end
      OpReturn: begin
        ctrlType_o = CtReturn;
        target_o   = rasTarget_i;  // Popped from the RAS.
      end
      default: begin
        isCtrl_o = 1'b0;  // Not a control transfer.
      end
    endcase
  end

endmodule

/* logic/fetchPkg.sv */
/* Widths, instruction formats, control types and the
   per-slot, resolve and update packets of fetch stage 2. */

package fetchPkg;

  localparam int FetchWidth  = 4;
  localparam int PcWidth     = 32;
  localparam int InstWidth   = 32;
  localparam int TagWidthMax = 8;  // Room for queues up to 256 deep.

  localparam logic [5:0] OpBranch = 6'h04;
  localparam logic [5:0] OpJump   = 6'h02;
  localparam logic [5:0] OpCall   = 6'h03;
  localparam logic [5:0] OpReturn = 6'h08;

  typedef logic [TagWidthMax-1:0] ctiTag_t;

  typedef struct packed {
    logic [5:0]         opcode;
    logic [9:0]         srcRegs;
    logic signed [15:0] offset;   // Word offset from pc+4.
  } branchFmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] index;           // Word index within the 256 MB region.
  } jumpFmt_t;

  typedef union packed {
    branchFmt_t br;
    jumpFmt_t   jmp;
  } instWord_u;

  typedef enum logic [1:0] {
    CtReturn = 2'd0,
    CtCall   = 2'd1,
    CtJump   = 2'd2,
    CtBranch = 2'd3                // Only conditional type.
  } ctrlType_e;

  typedef struct packed {
    logic [InstWidth-1:0] inst;
    logic [PcWidth-1:0]   pc;
    logic [PcWidth-1:0]   target;
    ctiTag_t              tag;
    logic                 predTaken;
  } instPacket_t;

  typedef struct packed {
    logic               valid;
    ctiTag_t            tag;
    logic [PcWidth-1:0] target;
    logic               taken;
    logic               mispredict;
  } ctiResolve_t;

  typedef struct packed {
    logic [PcWidth-1:0] pc;
    logic [PcWidth-1:0] target;
    ctrlType_e          ctrlType;
    logic               taken;
  } ctiUpdate_t;

endpackage
